//--- sources.f
hdl/llc_pkg.sv
hdl/llc_bram.sv
hdl/llc_field_bank.sv
hdl/llc_evict_mem.sv
hdl/llc_localmem.sv
tests/llc_localmem_assertions.sv
tests/llc_localmem_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -j 0 --top-module llc_localmem_tb -Mdir obj_dir -f sources.f
	out="$$(./obj_dir/Vllc_localmem_tb)"; echo "$$out"; \
	echo "$$out" | grep -q -x "all tests passed"

clean:
	rm -rf obj_dir

//--- tests/llc_localmem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module llc_localmem_tb;

    typedef enum int {
        op_write,
        op_flush,
        op_flush_write,
        op_evict,
        op_read,
        op_hold
    } op_kind_t;

    logic clk;
    logic rst_n;
    llc_pkg::llc_set_t set;
    llc_pkg::llc_way_t way;
    logic rd_en;
    logic wr_en;
    llc_pkg::way_mask_t wr_rst_flush;
    logic wr_en_evict_way;
    llc_pkg::line_t wr_data_line;
    llc_pkg::llc_tag_t wr_data_tag;
    llc_pkg::llc_state_t wr_data_state;
    logic wr_data_dirty_bit;
    llc_pkg::sharers_t wr_data_sharers;
    llc_pkg::llc_way_t wr_data_evict_way;
    llc_pkg::line_t rd_data_line [llc_pkg::num_ways];
    llc_pkg::llc_tag_t rd_data_tag [llc_pkg::num_ways];
    llc_pkg::llc_state_t rd_data_state [llc_pkg::num_ways];
    logic rd_data_dirty_bit [llc_pkg::num_ways];
    llc_pkg::sharers_t rd_data_sharers [llc_pkg::num_ways];
    llc_pkg::llc_way_t rd_data_evict_way;

    // reference model, one entry per set and way
    llc_pkg::line_t model_line [2**llc_pkg::llc_set_bits][llc_pkg::num_ways];
    llc_pkg::llc_tag_t model_tag [2**llc_pkg::llc_set_bits][llc_pkg::num_ways];
    llc_pkg::llc_state_t model_state [2**llc_pkg::llc_set_bits][llc_pkg::num_ways];
    logic model_dirty [2**llc_pkg::llc_set_bits][llc_pkg::num_ways];
    llc_pkg::sharers_t model_sharers [2**llc_pkg::llc_set_bits][llc_pkg::num_ways];
    llc_pkg::llc_way_t model_evict [2**llc_pkg::llc_set_bits];

    // values the outputs should show since the last read
    llc_pkg::line_t exp_line [llc_pkg::num_ways];
    llc_pkg::llc_tag_t exp_tag [llc_pkg::num_ways];
    llc_pkg::llc_state_t exp_state [llc_pkg::num_ways];
    logic exp_dirty [llc_pkg::num_ways];
    llc_pkg::sharers_t exp_sharers [llc_pkg::num_ways];
    llc_pkg::llc_way_t exp_evict;

    string test_names [$];
    int op_test [$];
    op_kind_t op_kind [$];
    llc_pkg::llc_set_t op_set [$];
    llc_pkg::llc_way_t op_way [$];
    llc_pkg::way_mask_t op_mask [$];

    int seed;
    int read_timeout = 8;
    int test_errors;
    int tests_passed;
    int tests_failed;
    bit timed_out;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    llc_localmem dut_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .set               (set),
        .way               (way),
        .rd_en             (rd_en),
        .wr_en             (wr_en),
        .wr_rst_flush      (wr_rst_flush),
        .wr_en_evict_way   (wr_en_evict_way),
        .wr_data_line      (wr_data_line),
        .wr_data_tag       (wr_data_tag),
        .wr_data_state     (wr_data_state),
        .wr_data_dirty_bit (wr_data_dirty_bit),
        .wr_data_sharers   (wr_data_sharers),
        .wr_data_evict_way (wr_data_evict_way),
        .rd_data_line      (rd_data_line),
        .rd_data_tag       (rd_data_tag),
        .rd_data_state     (rd_data_state),
        .rd_data_dirty_bit (rd_data_dirty_bit),
        .rd_data_sharers   (rd_data_sharers),
        .rd_data_evict_way (rd_data_evict_way)
    );

    task automatic add_op(input int t, input op_kind_t k, input llc_pkg::llc_set_t s,
                          input llc_pkg::llc_way_t w, input llc_pkg::way_mask_t m);
        op_test.push_back(t);
        op_kind.push_back(k);
        op_set.push_back(s);
        op_way.push_back(w);
        op_mask.push_back(m);
    endtask

    task automatic build_table();
        test_names.push_back("write_all_ways");
        for (int w = 0; w < llc_pkg::num_ways; w++) begin
            add_op(0, op_write, 8'h10, llc_pkg::llc_way_t'(w), 4'h0);
        end
        add_op(0, op_read, 8'h10, 2'd0, 4'h0);
        add_op(0, op_write, 8'h10, 2'd2, 4'h0);
        add_op(0, op_read, 8'h10, 2'd0, 4'h0);

        // same low bits, different top bit, so different line and tag banks
        test_names.push_back("bank_split");
        add_op(1, op_write, 8'h05, 2'd1, 4'h0);
        add_op(1, op_write, 8'h85, 2'd1, 4'h0);
        add_op(1, op_read, 8'h05, 2'd0, 4'h0);
        add_op(1, op_read, 8'h85, 2'd0, 4'h0);
        add_op(1, op_read, 8'h05, 2'd0, 4'h0);
        add_op(1, op_read, 8'h85, 2'd0, 4'h0);

        // the addressed way is skipped while wr_en is low, hence two passes
        test_names.push_back("flush_all_ways");
        add_op(2, op_flush, 8'h10, 2'd0, 4'hf);
        add_op(2, op_read, 8'h10, 2'd0, 4'h0);
        add_op(2, op_flush, 8'h10, 2'd1, 4'hf);
        add_op(2, op_read, 8'h10, 2'd0, 4'h0);

        // way 2 takes the write, way 0 the flush, ways 1 and 3 keep their state
        test_names.push_back("flush_with_write");
        add_op(3, op_flush_write, 8'h33, 2'd2, 4'b0101);
        add_op(3, op_read, 8'h33, 2'd0, 4'h0);

        test_names.push_back("evict_banks");
        add_op(4, op_evict, 8'h21, 2'd0, 4'h0);
        add_op(4, op_evict, 8'ha1, 2'd0, 4'h0);
        add_op(4, op_read, 8'h21, 2'd0, 4'h0);
        add_op(4, op_read, 8'ha1, 2'd0, 4'h0);
        add_op(4, op_read, 8'h21, 2'd0, 4'h0);

        test_names.push_back("read_hold");
        add_op(5, op_read, 8'h42, 2'd0, 4'h0);
        add_op(5, op_write, 8'h42, 2'd0, 4'h0);
        add_op(5, op_flush, 8'h42, 2'd1, 4'hf);
        add_op(5, op_evict, 8'h42, 2'd0, 4'h0);
        // idle cycle addresses the other line and tag bank
        add_op(5, op_hold, 8'hc2, 2'd0, 4'h0);
        add_op(5, op_read, 8'h42, 2'd0, 4'h0);
    endtask

    task automatic drive_op(input op_kind_t kind, input llc_pkg::llc_set_t s,
                            input llc_pkg::llc_way_t w, input llc_pkg::way_mask_t m);
        llc_pkg::line_t line_v;
        llc_pkg::llc_tag_t tag_v;
        llc_pkg::llc_state_t state_v;
        logic dirty_v;
        llc_pkg::sharers_t sharers_v;
        llc_pkg::llc_way_t evict_v;
        logic do_write;
        logic do_flush;
        line_v = {$random(seed), $random(seed), $random(seed), $random(seed)};
        tag_v = llc_pkg::llc_tag_t'($random(seed));
        state_v = llc_pkg::llc_state_t'($random(seed));
        dirty_v = 1'($random(seed));
        sharers_v = llc_pkg::sharers_t'($random(seed));
        evict_v = llc_pkg::llc_way_t'($random(seed));
        do_write = (kind == op_write) || (kind == op_flush_write);
        do_flush = (kind == op_flush) || (kind == op_flush_write);
        @(posedge clk);
        set <= s;
        way <= w;
        rd_en <= (kind == op_read);
        wr_en <= do_write;
        wr_rst_flush <= do_flush ? m : '0;
        wr_en_evict_way <= (kind == op_evict);
        wr_data_line <= line_v;
        wr_data_tag <= tag_v;
        wr_data_state <= state_v;
        wr_data_dirty_bit <= dirty_v;
        wr_data_sharers <= sharers_v;
        wr_data_evict_way <= evict_v;
        // addressed way follows wr_en, other flagged ways take the flush data
        for (int i = 0; i < llc_pkg::num_ways; i++) begin
            if (llc_pkg::llc_way_t'(i) == w) begin
                if (do_write) begin
                    model_line[s][i] = line_v;
                    model_tag[s][i] = tag_v;
                    model_state[s][i] = state_v;
                    model_dirty[s][i] = dirty_v;
                    model_sharers[s][i] = sharers_v;
                end
            end else if (do_flush && m[i]) begin
                model_state[s][i] = state_v;
                model_dirty[s][i] = dirty_v;
                model_sharers[s][i] = sharers_v;
            end
        end
        if (kind == op_evict) begin
            model_evict[s] = evict_v;
        end
    endtask

    // fill every entry so no read ever returns unwritten data
    task automatic preload_all();
        for (int s = 0; s < 2**llc_pkg::llc_set_bits; s++) begin
            for (int w = 0; w < llc_pkg::num_ways; w++) begin
                drive_op(op_write, llc_pkg::llc_set_t'(s), llc_pkg::llc_way_t'(w), '0);
            end
            drive_op(op_evict, llc_pkg::llc_set_t'(s), '0, '0);
        end
    endtask

    task automatic load_expected(input llc_pkg::llc_set_t s);
        for (int w = 0; w < llc_pkg::num_ways; w++) begin
            exp_line[w] = model_line[s][w];
            exp_tag[w] = model_tag[s][w];
            exp_state[w] = model_state[s][w];
            exp_dirty[w] = model_dirty[s][w];
            exp_sharers[w] = model_sharers[s][w];
        end
        exp_evict = model_evict[s];
    endtask

    // rd_en still reads high in the active region of the edge that samples it
    task automatic wait_read_sample(output bit timeout_hit);
        int cycles;
        cycles = 0;
        timeout_hit = 1'b0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!rd_en && cycles < read_timeout);
        if (!rd_en) begin
            timeout_hit = 1'b1;
        end
        rd_en <= 1'b0;
        @(negedge clk);
    endtask

    task automatic check_outputs(input string name);
        for (int w = 0; w < llc_pkg::num_ways; w++) begin
            assert (rd_data_line[w] === exp_line[w]) else begin
                $display("FAILED %s line way %0d: expected %h actual %h",
                         name, w, exp_line[w], rd_data_line[w]);
                test_errors++;
            end
            assert (rd_data_tag[w] === exp_tag[w]) else begin
                $display("FAILED %s tag way %0d: expected %h actual %h",
                         name, w, exp_tag[w], rd_data_tag[w]);
                test_errors++;
            end
            assert (rd_data_state[w] === exp_state[w]) else begin
                $display("FAILED %s state way %0d: expected %h actual %h",
                         name, w, exp_state[w], rd_data_state[w]);
                test_errors++;
            end
            assert (rd_data_dirty_bit[w] === exp_dirty[w]) else begin
                $display("FAILED %s dirty way %0d: expected %b actual %b",
                         name, w, exp_dirty[w], rd_data_dirty_bit[w]);
                test_errors++;
            end
            assert (rd_data_sharers[w] === exp_sharers[w]) else begin
                $display("FAILED %s sharers way %0d: expected %h actual %h",
                         name, w, exp_sharers[w], rd_data_sharers[w]);
                test_errors++;
            end
        end
        assert (rd_data_evict_way === exp_evict) else begin
            $display("FAILED %s evict way: expected %h actual %h",
                     name, exp_evict, rd_data_evict_way);
            test_errors++;
        end
    endtask

    task automatic apply_op(input int i);
        bit timeout_hit;
        drive_op(op_kind[i], op_set[i], op_way[i], op_mask[i]);
        if (op_kind[i] == op_read) begin
            load_expected(op_set[i]);
            wait_read_sample(timeout_hit);
            if (timeout_hit) begin
                $display("read of set %h was not sampled by the DUT within %0d cycles",
                         op_set[i], read_timeout);
                timed_out = 1'b1;
            end else begin
                check_outputs(test_names[op_test[i]]);
            end
        end else if (op_kind[i] == op_hold) begin
            @(negedge clk);
            check_outputs(test_names[op_test[i]]);
        end
    endtask

    initial begin
        seed = 32'h357f_e6c6;
        timed_out = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        rst_n = 1'b0;
        set = '0;
        way = '0;
        rd_en = 1'b0;
        wr_en = 1'b0;
        wr_rst_flush = '0;
        wr_en_evict_way = 1'b0;
        wr_data_line = '0;
        wr_data_tag = '0;
        wr_data_state = '0;
        wr_data_dirty_bit = 1'b0;
        wr_data_sharers = '0;
        wr_data_evict_way = '0;
        build_table();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        preload_all();
        for (int t = 0; t < test_names.size(); t++) begin
            if (!timed_out) begin
                test_errors = 0;
                for (int i = 0; i < op_test.size(); i++) begin
                    if (op_test[i] == t && !timed_out) begin
                        apply_op(i);
                    end
                end
                if (test_errors == 0 && !timed_out) begin
                    $display("test %s passed", test_names[t]);
                    tests_passed++;
                end else begin
                    $display("test %s failed with %0d errors", test_names[t], test_errors);
                    tests_failed++;
                end
            end
        end
        $display("%0d passed, %0d failed", tests_passed, tests_failed);
        if (!timed_out && tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/llc_localmem_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module llc_localmem_assertions (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 rd_en,
    input llc_pkg::way_mask_t   way_wr_en,
    input llc_pkg::way_mask_t   way_flush_wr_en,
    input llc_pkg::line_t       rd_data_line [llc_pkg::num_ways],
    input llc_pkg::llc_tag_t    rd_data_tag [llc_pkg::num_ways],
    input llc_pkg::llc_state_t  rd_data_state [llc_pkg::num_ways],
    input logic                 rd_data_dirty_bit [llc_pkg::num_ways],
    input llc_pkg::sharers_t    rd_data_sharers [llc_pkg::num_ways],
    input llc_pkg::llc_way_t    rd_data_evict_way
);

    // only the addressed way can take a full write
    way_wr_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(way_wr_en))
        else $error("way write enable has more than one bit set");

    way_wr_in_flush_a: assert property (@(posedge clk) disable iff (!rst_n)
        (way_wr_en & ~way_flush_wr_en) == '0)
        else $error("way write enable without matching flush write enable");

    genvar w;
    generate
        for (w = 0; w < llc_pkg::num_ways; w++) begin : g_way
            rd_known_a: assert property (@(posedge clk) disable iff (!rst_n)
                rd_en |=> !$isunknown({rd_data_line[w], rd_data_tag[w], rd_data_state[w],
                                       rd_data_dirty_bit[w], rd_data_sharers[w]}))
                else $error("unknown read data on way %0d after rd_en", w);
        end
    endgenerate

    evict_known_a: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |=> !$isunknown(rd_data_evict_way))
        else $error("unknown eviction way after rd_en");

endmodule

bind llc_localmem llc_localmem_assertions assertions_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .rd_en             (rd_en),
    .way_wr_en         (way_wr_en),
    .way_flush_wr_en   (way_flush_wr_en),
    .rd_data_line      (rd_data_line),
    .rd_data_tag       (rd_data_tag),
    .rd_data_state     (rd_data_state),
    .rd_data_dirty_bit (rd_data_dirty_bit),
    .rd_data_sharers   (rd_data_sharers),
    .rd_data_evict_way (rd_data_evict_way)
);

`default_nettype wire

//--- hdl/llc_localmem.sv
`timescale 1ns/1ps
`default_nettype none

module llc_localmem (
    input  logic                 clk,
    input  logic                 rst_n,
    input  llc_pkg::llc_set_t    set,
    input  llc_pkg::llc_way_t    way,
    input  logic                 rd_en,
    input  logic                 wr_en,
    input  llc_pkg::way_mask_t   wr_rst_flush,
    input  logic                 wr_en_evict_way,
    input  llc_pkg::line_t       wr_data_line,
    input  llc_pkg::llc_tag_t    wr_data_tag,
    input  llc_pkg::llc_state_t  wr_data_state,
    input  logic                 wr_data_dirty_bit,
    input  llc_pkg::sharers_t    wr_data_sharers,
    input  llc_pkg::llc_way_t    wr_data_evict_way,
    output llc_pkg::line_t       rd_data_line [llc_pkg::num_ways],
    output llc_pkg::llc_tag_t    rd_data_tag [llc_pkg::num_ways],
    output llc_pkg::llc_state_t  rd_data_state [llc_pkg::num_ways],
    output logic                 rd_data_dirty_bit [llc_pkg::num_ways],
    output llc_pkg::sharers_t    rd_data_sharers [llc_pkg::num_ways],
    output llc_pkg::llc_way_t    rd_data_evict_way
);

    llc_pkg::way_mask_t way_wr_en;
    llc_pkg::way_mask_t way_flush_wr_en;

    // the addressed way follows wr_en, the other ways follow their flush bit
    always_comb begin
        for (int i = 0; i < llc_pkg::num_ways; i++) begin
            if (way == llc_pkg::llc_way_bits'(i)) begin
                way_wr_en[i] = wr_en;
                way_flush_wr_en[i] = wr_en;
            end else begin
                way_wr_en[i] = 1'b0;
                way_flush_wr_en[i] = wr_rst_flush[i];
            end
        end
    end

    // line and tag are never touched by a flush
    llc_field_bank #(
        .field_t   (llc_pkg::line_t),
        .bank_bits (llc_pkg::line_bank_bits)
    ) line_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .set       (set),
        .rd_en     (rd_en),
        .wr_en_way (way_wr_en),
        .wr_data   (wr_data_line),
        .rd_data   (rd_data_line)
    );

    llc_field_bank #(
        .field_t   (llc_pkg::llc_tag_t),
        .bank_bits (llc_pkg::tag_bank_bits)
    ) tag_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .set       (set),
        .rd_en     (rd_en),
        .wr_en_way (way_wr_en),
        .wr_data   (wr_data_tag),
        .rd_data   (rd_data_tag)
    );

    llc_field_bank #(
        .field_t   (llc_pkg::llc_state_t),
        .bank_bits (llc_pkg::state_bank_bits)
    ) state_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .set       (set),
        .rd_en     (rd_en),
        .wr_en_way (way_flush_wr_en),
        .wr_data   (wr_data_state),
        .rd_data   (rd_data_state)
    );

    llc_field_bank #(
        .field_t   (logic),
        .bank_bits (llc_pkg::dirty_bank_bits)
    ) dirty_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .set       (set),
        .rd_en     (rd_en),
        .wr_en_way (way_flush_wr_en),
        .wr_data   (wr_data_dirty_bit),
        .rd_data   (rd_data_dirty_bit)
    );

    llc_field_bank #(
        .field_t   (llc_pkg::sharers_t),
        .bank_bits (llc_pkg::sharers_bank_bits)
    ) sharers_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .set       (set),
        .rd_en     (rd_en),
        .wr_en_way (way_flush_wr_en),
        .wr_data   (wr_data_sharers),
        .rd_data   (rd_data_sharers)
    );

    // one pointer per set, not per way
    llc_evict_mem evict_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .set     (set),
        .rd_en   (rd_en),
        .wr_en   (wr_en_evict_way),
        .wr_data (wr_data_evict_way),
        .rd_data (rd_data_evict_way)
    );

endmodule

`default_nettype wire

//--- hdl/llc_evict_mem.sv
`timescale 1ns/1ps
`default_nettype none

module llc_evict_mem (
    input  logic               clk,
    input  logic               rst_n,
    input  llc_pkg::llc_set_t  set,
    input  logic               rd_en,
    input  logic               wr_en,
    input  llc_pkg::llc_way_t  wr_data,
    output llc_pkg::llc_way_t  rd_data
);

    localparam int bank_bits = llc_pkg::evict_bank_bits;
    localparam int num_banks = 1 << bank_bits;
    localparam int entry_bits = llc_pkg::llc_set_bits - bank_bits;

    logic [entry_bits-1:0] entry;
    logic [bank_bits-1:0] wr_bank;
    logic [bank_bits-1:0] rd_bank;
    llc_pkg::llc_way_t bank_rd_data [num_banks];

    assign entry = set[entry_bits-1:0];
    assign wr_bank = set[llc_pkg::llc_set_bits-1 -: bank_bits];

    genvar b;
    generate
        for (b = 0; b < num_banks; b++) begin : g_bank
            llc_pkg::llc_way_t mem [2**entry_bits];
            llc_pkg::llc_way_t rd_q;

            always_ff @(posedge clk) begin
                if (rd_en) begin
                    rd_q <= mem[entry];
                end
                if (wr_en && (wr_bank == bank_bits'(b))) begin
                    mem[entry] <= wr_data;
                end
            end

            assign bank_rd_data[b] = rd_q;
        end
    endgenerate

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_bank <= '0;
        end else if (rd_en) begin
            rd_bank <= wr_bank;
        end
    end

    assign rd_data = bank_rd_data[rd_bank];

endmodule

`default_nettype wire

//--- hdl/llc_field_bank.sv
`timescale 1ns/1ps
`default_nettype none

module llc_field_bank #(
    parameter type field_t = logic,
    parameter int bank_bits = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  llc_pkg::llc_set_t     set,
    input  logic                  rd_en,
    input  llc_pkg::way_mask_t    wr_en_way,
    input  field_t                wr_data,
    output field_t                rd_data [llc_pkg::num_ways]
);

    localparam int num_banks = 1 << bank_bits;
    localparam int entry_bits = llc_pkg::llc_set_bits - bank_bits;
    localparam int num_pairs = llc_pkg::num_ways / 2;

    logic [entry_bits-1:0] entry;
    logic [num_banks-1:0] bank_wr_en;
    field_t bank_rd_data [num_banks][llc_pkg::num_ways];

    assign entry = set[entry_bits-1:0];

    genvar b;
    genvar p;
    generate
        for (b = 0; b < num_banks; b++) begin : g_bank
            // ways 2p and 2p+1 share one RAM, way picks the upper half
            for (p = 0; p < num_pairs; p++) begin : g_pair
                llc_bram #(
                    .payload_t (field_t),
                    .addr_bits (entry_bits + 1)
                ) bram_i (
                    .clk       (clk),
                    .addr_a    ({1'b0, entry}),
                    .addr_b    ({1'b1, entry}),
                    .wr_data_a (wr_data),
                    .wr_data_b (wr_data),
                    .wr_en_a   (wr_en_way[2*p] & bank_wr_en[b]),
                    .wr_en_b   (wr_en_way[2*p+1] & bank_wr_en[b]),
                    .rd_en     (rd_en),
                    .rd_data_a (bank_rd_data[b][2*p]),
                    .rd_data_b (bank_rd_data[b][2*p+1])
                );
            end
        end

        if (bank_bits == 0) begin : g_single
            assign bank_wr_en = 1'b1;

            always_comb begin
                for (int w = 0; w < llc_pkg::num_ways; w++) begin
                    rd_data[w] = bank_rd_data[0][w];
                end
            end
        end else begin : g_banked
            logic [bank_bits-1:0] wr_bank;
            logic [bank_bits-1:0] rd_bank;

            assign wr_bank = set[llc_pkg::llc_set_bits-1 -: bank_bits];

            for (b = 0; b < num_banks; b++) begin : g_wr_sel
                assign bank_wr_en[b] = (wr_bank == bank_bits'(b));
            end

            // remember which bank was read so the mux follows the RAM output
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    rd_bank <= '0;
                end else if (rd_en) begin
                    rd_bank <= wr_bank;
                end
            end

            always_comb begin
                for (int w = 0; w < llc_pkg::num_ways; w++) begin
                    rd_data[w] = bank_rd_data[rd_bank][w];
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

//--- hdl/llc_bram.sv
`timescale 1ns/1ps
`default_nettype none

module llc_bram #(
    parameter type payload_t = logic,
    parameter int addr_bits = 8
) (
    input  logic                 clk,
    input  logic [addr_bits-1:0] addr_a,
    input  logic [addr_bits-1:0] addr_b,
    input  payload_t             wr_data_a,
    input  payload_t             wr_data_b,
    input  logic                 wr_en_a,
    input  logic                 wr_en_b,
    input  logic                 rd_en,
    output payload_t             rd_data_a,
    output payload_t             rd_data_b
);

    localparam int depth = 2 ** addr_bits;

    payload_t mem [depth];

    // both ports read before write, so a same-address access returns old data
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data_a <= mem[addr_a];
            rd_data_b <= mem[addr_b];
        end
        if (wr_en_a) begin
            mem[addr_a] <= wr_data_a;
        end
        if (wr_en_b) begin
            mem[addr_b] <= wr_data_b;
        end
    end

endmodule

`default_nettype wire

//--- hdl/llc_pkg.sv
`default_nettype none

package llc_pkg;

    // cache geometry
    localparam int num_ways = 4;
    localparam int llc_set_bits = 8;
    localparam int llc_way_bits = 2;
    localparam int llc_tag_bits = 16;
    localparam int llc_state_bits = 3;
    localparam int line_bits = 128;
    localparam int num_sharers = 16;

    // banking per field array, top set bits pick the bank
    localparam int line_bank_bits = 1;
    localparam int tag_bank_bits = 1;
    localparam int state_bank_bits = 0;
    localparam int dirty_bank_bits = 0;
    localparam int sharers_bank_bits = 0;
    localparam int evict_bank_bits = 1;

    typedef logic [llc_set_bits-1:0] llc_set_t;

    typedef logic [llc_way_bits-1:0] llc_way_t;

    typedef logic [line_bits-1:0] line_t;

    typedef logic [llc_tag_bits-1:0] llc_tag_t;

    typedef logic [llc_state_bits-1:0] llc_state_t;

    typedef logic [num_sharers-1:0] sharers_t;

    // one bit per way, used for flush masks and way write enables
    typedef logic [num_ways-1:0] way_mask_t;

endpackage

`default_nettype wire
